//--- design/eeprom_defines.svh
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// 24C16 organisation, 2K x 8
`define EE_ADDR_W 11
`define EE_DATA_W 8

// upper nibble of the device-select byte
`define EE_DEV_TYPE 4'b1010

// CLK cycles per quarter of one scl period
`define EE_SCL_QUARTER 2

`endif

//--- design/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    typedef logic [7:0] bus_byte_t;

    typedef enum logic [1:0]
    {
        op_start,
        op_stop,
        op_write,
        op_read
    } bus_op_e;

    // mack set means the master acknowledges a read byte
    typedef struct packed
    {
        bus_op_e   op;
        bus_byte_t data;
        logic      mack;
    } bus_cmd_t;

    typedef struct packed
    {
        bus_byte_t data;
        logic      no_ack; // ninth bit seen released
    } bus_rsp_t;

    typedef enum logic [1:0]
    {
        bit_idle,
        bit_start,
        bit_stop,
        bit_byte
    } bit_state_e;

endpackage

`default_nettype wire

//--- design/eeprom_pkg.sv
`default_nettype none

`include "eeprom_defines.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_DATA_W-1:0] ee_data_t;

    typedef struct packed
    {
        logic     rd;   // random read, else byte write
        ee_addr_t addr;
        ee_data_t data;
    } ee_req_t;

    typedef struct packed
    {
        ee_data_t rd_data;
        logic     nack;
    } ee_result_t;

    typedef enum logic [3:0]
    {
        seq_idle,
        seq_start,
        seq_ctrl_wr,
        seq_addr,
        seq_data_wr,
        seq_restart,
        seq_ctrl_rd,
        seq_data_rd,
        seq_stop,
        seq_finish
    } ee_seq_state_e;

endpackage

`default_nettype wire

//--- design/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defines.svh"

module i2c_bit_engine
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    input  i2c_bus_pkg::bus_cmd_t cmd,
    input  logic                  sda_in,
    output logic                  cmd_done,
    output i2c_bus_pkg::bus_rsp_t rsp,
    output logic                  scl,
    output logic                  sda_pull
);

    localparam int QW = (`EE_SCL_QUARTER > 1) ? $clog2(`EE_SCL_QUARTER) : 1;

    i2c_bus_pkg::bit_state_e state;

    logic [QW-1:0] qcnt;
    logic [1:0]    phase;     // quarter within the current scl period
    logic [3:0]    bitcnt;
    logic [8:0]    tx;        // 1 = release sda
    logic [8:0]    rx;
    logic [8:0]    tx_load;
    logic          q_end;

    // reads release the data bits and send the master ack last
    assign tx_load = (cmd.op == i2c_bus_pkg::op_read) ? {8'hff, ~cmd.mack} : {cmd.data, 1'b1};

    assign q_end = (qcnt == QW'(`EE_SCL_QUARTER - 1));

    assign rsp.data   = rx[8:1];
    assign rsp.no_ack = rx[0];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= i2c_bus_pkg::bit_idle;
            qcnt     <= '0;
            phase    <= 2'd0;
            bitcnt   <= 4'd0;
            cmd_done <= 1'b0;
            scl      <= 1'b1;
            sda_pull <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            case (state)
                i2c_bus_pkg::bit_idle:
                begin
                    // lines hold their last level between commands
                    if (cmd_valid)
                    begin
                        qcnt   <= '0;
                        phase  <= 2'd0;
                        bitcnt <= 4'd0;
                        tx     <= tx_load;
                        scl    <= 1'b0;
                        case (cmd.op)
                            i2c_bus_pkg::op_start:
                            begin
                                state    <= i2c_bus_pkg::bit_start;
                                sda_pull <= 1'b0;
                            end
                            i2c_bus_pkg::op_stop:
                            begin
                                state    <= i2c_bus_pkg::bit_stop;
                                sda_pull <= 1'b1;
                            end
                            default:
                            begin
                                state    <= i2c_bus_pkg::bit_byte;
                                sda_pull <= ~tx_load[8];
                            end
                        endcase
                    end
                end
                default:
                begin
                    if (!q_end)
                    begin
                        qcnt <= qcnt + 1'b1;
                    end
                    else
                    begin
                        qcnt  <= '0;
                        phase <= phase + 2'd1;
                        case (phase)
                            2'd0: scl <= 1'b1;
                            2'd1:
                            begin
                                if (state == i2c_bus_pkg::bit_start)
                                    sda_pull <= 1'b1;     // sda falls with scl high
                                else if (state == i2c_bus_pkg::bit_stop)
                                    sda_pull <= 1'b0;     // sda rises with scl high
                                else
                                    rx <= {rx[7:0], sda_in}; // middle of scl high
                            end
                            2'd2:
                            begin
                                if (state != i2c_bus_pkg::bit_stop)
                                    scl <= 1'b0;
                            end
                            default:
                            begin
                                if (state == i2c_bus_pkg::bit_byte && bitcnt != 4'd8)
                                begin
                                    bitcnt   <= bitcnt + 4'd1;
                                    tx       <= {tx[7:0], 1'b1};
                                    sda_pull <= ~tx[7];   // next bit while scl low
                                end
                                else
                                begin
                                    state    <= i2c_bus_pkg::bit_idle;
                                    cmd_done <= 1'b1;
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // the sequencer has to wait for cmd_done before the next command
    a_no_overlap: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> state == i2c_bus_pkg::bit_idle);

endmodule

`default_nettype wire

//--- design/eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defines.svh"

module eeprom_sequencer
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    start,
    input  eeprom_pkg::ee_req_t     req,
    input  logic                    cmd_done,
    input  i2c_bus_pkg::bus_rsp_t   rsp,
    output logic                    cmd_valid,
    output i2c_bus_pkg::bus_cmd_t   cmd,
    output logic                    done,
    output eeprom_pkg::ee_result_t  result
);

    eeprom_pkg::ee_seq_state_e state;
    eeprom_pkg::ee_seq_state_e nxt_state;

    i2c_bus_pkg::bus_cmd_t  nxt_cmd;
    i2c_bus_pkg::bus_byte_t dev_sel;
    eeprom_pkg::ee_data_t   rd_q;
    logic                   nack_q;
    logic                   issued;     // command of this state sent
    logic                   slave_nack;

    // device select with the write bit and bits 10..8 as block address
    assign dev_sel = {`EE_DEV_TYPE, req.addr[10:8], 1'b0};

    // only bytes we sent carry a slave acknowledge
    assign slave_nack = rsp.no_ack && (cmd.op == i2c_bus_pkg::op_write);

    assign result.rd_data = rd_q;
    assign result.nack    = nack_q;

    always_comb
    begin
        nxt_cmd.op   = i2c_bus_pkg::op_write;
        nxt_cmd.data = 8'hff;
        nxt_cmd.mack = 1'b0;
        nxt_state    = state;
        case (state)
            eeprom_pkg::seq_start:
            begin
                nxt_cmd.op = i2c_bus_pkg::op_start;
                nxt_state  = eeprom_pkg::seq_ctrl_wr;
            end
            eeprom_pkg::seq_ctrl_wr:
            begin
                nxt_cmd.data = dev_sel;
                nxt_state    = slave_nack ? eeprom_pkg::seq_stop : eeprom_pkg::seq_addr;
            end
            eeprom_pkg::seq_addr:
            begin
                nxt_cmd.data = req.addr[7:0];
                if (slave_nack)
                    nxt_state = eeprom_pkg::seq_stop;
                else if (req.rd)
                    nxt_state = eeprom_pkg::seq_restart;
                else
                    nxt_state = eeprom_pkg::seq_data_wr;
            end
            eeprom_pkg::seq_data_wr:
            begin
                nxt_cmd.data = req.data;
                nxt_state    = eeprom_pkg::seq_stop;
            end
            eeprom_pkg::seq_restart:
            begin
                nxt_cmd.op = i2c_bus_pkg::op_start; // repeated start
                nxt_state  = eeprom_pkg::seq_ctrl_rd;
            end
            eeprom_pkg::seq_ctrl_rd:
            begin
                nxt_cmd.data = {dev_sel[7:1], 1'b1};
                nxt_state    = slave_nack ? eeprom_pkg::seq_stop : eeprom_pkg::seq_data_rd;
            end
            eeprom_pkg::seq_data_rd:
            begin
                nxt_cmd.op   = i2c_bus_pkg::op_read;
                nxt_cmd.mack = 1'b0;   // single byte without master ack
                nxt_state    = eeprom_pkg::seq_stop;
            end
            eeprom_pkg::seq_stop:
            begin
                nxt_cmd.op = i2c_bus_pkg::op_stop;
                nxt_state  = eeprom_pkg::seq_finish;
            end
            default:
            begin
                nxt_state = state;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::seq_idle;
            issued    <= 1'b0;
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            nack_q    <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            case (state)
                eeprom_pkg::seq_idle:
                begin
                    if (start)
                    begin
                        state  <= eeprom_pkg::seq_start;
                        nack_q <= 1'b0;
                    end
                end
                eeprom_pkg::seq_finish:
                begin
                    done  <= 1'b1;
                    state <= eeprom_pkg::seq_idle;
                end
                default:
                begin
                    if (!issued)
                    begin
                        cmd_valid <= 1'b1;
                        issued    <= 1'b1;
                    end
                    else if (cmd_done)
                    begin
                        issued <= 1'b0;
                        state  <= nxt_state;
                        if (slave_nack)
                            nack_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!issued && state != eeprom_pkg::seq_idle)
            cmd <= nxt_cmd;
        if (state == eeprom_pkg::seq_data_rd && issued && cmd_done)
            rd_q <= rsp.data;
    end

    // bit engine stays silent while no transaction runs
    a_idle_quiet: assert property (@(posedge CLK) disable iff (RESET)
        state == eeprom_pkg::seq_idle |-> !cmd_done);

endmodule

`default_nettype wire

//--- design/eeprom_req_regs.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_req_regs
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   wr,
    input  logic                   rd,
    input  eeprom_pkg::ee_addr_t   addr,
    input  eeprom_pkg::ee_data_t   wr_data,
    input  logic                   done,
    input  eeprom_pkg::ee_result_t result,
    output logic                   start,
    output eeprom_pkg::ee_req_t    req,
    output logic                   busy,
    output logic                   ack,
    output logic                   nack,
    output eeprom_pkg::ee_data_t   rd_data
);

    logic accept;

    assign accept = !busy && (wr || rd); // strobes during busy are dropped

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start <= 1'b0;
            busy  <= 1'b0;
            ack   <= 1'b0;
            nack  <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            ack   <= 1'b0;
            if (accept)
            begin
                start <= 1'b1;
                busy  <= 1'b1;
            end
            else if (done)
            begin
                busy <= 1'b0;
                ack  <= 1'b1;
                nack <= result.nack;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req.rd   <= !wr;     // wr has priority
            req.addr <= addr;
            req.data <= wr_data;
        end
        if (done && req.rd)
            rd_data <= result.rd_data;  // writes keep the old value
    end

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

    // a request ends only while one is running
    a_done_busy: assert property (@(posedge CLK) disable iff (RESET)
        done |-> busy);

endmodule

`default_nettype wire

//--- design/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_data_t wr_data,
    output eeprom_pkg::ee_data_t rd_data,
    output logic                 ack,
    output logic                 nack,
    output logic                 busy,
    output logic                 scl,
    inout  wire                  sda
);

    eeprom_pkg::ee_req_t    req;
    eeprom_pkg::ee_result_t result;
    i2c_bus_pkg::bus_cmd_t  cmd;
    i2c_bus_pkg::bus_rsp_t  rsp;

    logic start;
    logic done;
    logic cmd_valid;
    logic cmd_done;
    logic sda_pull;
    logic sda_in;

    // open drain, pull-up sits on the board
    assign sda    = sda_pull ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_req_regs regs0
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .done    (done),
        .result  (result),
        .start   (start),
        .req     (req),
        .busy    (busy),
        .ack     (ack),
        .nack    (nack),
        .rd_data (rd_data)
    );

    eeprom_sequencer seq0
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .start     (start),
        .req       (req),
        .cmd_done  (cmd_done),
        .rsp       (rsp),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .done      (done),
        .result    (result)
    );

    i2c_bit_engine bit0
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .sda_in    (sda_in),
        .cmd_done  (cmd_done),
        .rsp       (rsp),
        .scl       (scl),
        .sda_pull  (sda_pull)
    );

endmodule

`default_nettype wire

//--- bench/eeprom_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defines.svh"

module eeprom_slave_model
(
    input  wire scl,
    inout  wire sda,
    input  wire present
);

    typedef enum logic [2:0]
    {
        sl_idle,
        sl_ctrl,
        sl_addr,
        sl_wdata,
        sl_rdata
    } slave_state_e;

    logic [`EE_DATA_W-1:0] mem [0:(1 << `EE_ADDR_W)-1];

    slave_state_e          state;
    slave_state_e          next_state;
    logic [3:0]            bitcnt;     // scl rising edges since start of byte
    logic [7:0]            shreg;
    logic [7:0]            tx_byte;
    logic [`EE_ADDR_W-1:0] ptr;
    logic                  drive_low;
    logic                  acked;
    logic                  master_ack;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin : init_model
        int i;
        for (i = 0; i < (1 << `EE_ADDR_W); i++)
            mem[i] = i[7:0] ^ 8'h5a;
        state      = sl_idle;
        next_state = sl_idle;
        bitcnt     = 4'd0;
        shreg      = 8'h00;
        tx_byte    = 8'hff;
        ptr        = '0;
        drive_low  = 1'b0;
        acked      = 1'b0;
        master_ack = 1'b0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state  = sl_ctrl;
            bitcnt = 4'd0;
        end
    end

    // stop
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = sl_idle;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state != sl_idle)
        begin
            if (bitcnt < 4'd8)
                shreg = {shreg[6:0], (sda !== 1'b0)};
            else if (bitcnt == 4'd8)
                master_ack = (sda === 1'b0);
            bitcnt = bitcnt + 4'd1;
        end
    end

    always @(negedge scl)
    begin
        if (state != sl_idle)
        begin
            if (bitcnt == 4'd8)
            begin
                acked = 1'b0;
                case (state)
                    sl_ctrl:
                    begin
                        if (present === 1'b1 && shreg[7:4] == `EE_DEV_TYPE)
                        begin
                            acked      = 1'b1;
                            ptr        = {shreg[3:1], ptr[7:0]}; // block bits of the address
                            next_state = shreg[0] ? sl_rdata : sl_addr;
                        end
                    end
                    sl_addr:
                    begin
                        acked      = 1'b1;
                        ptr[7:0]   = shreg;
                        next_state = sl_wdata;
                    end
                    sl_wdata:
                    begin
                        acked      = 1'b1;
                        mem[ptr]   = shreg;   // no write cycle delay
                        next_state = sl_wdata;
                    end
                    default:
                    begin
                        acked = 1'b0;         // master owns the ack slot
                    end
                endcase
                drive_low = acked;
            end
            else if (bitcnt == 4'd9)
            begin
                bitcnt    = 4'd0;
                drive_low = 1'b0;
                if (state == sl_rdata)
                begin
                    ptr = ptr + 1'b1;
                    if (!master_ack)
                        state = sl_idle;
                end
                else
                    state = acked ? next_state : sl_idle;
                if (state == sl_rdata)
                begin
                    tx_byte   = mem[ptr];
                    drive_low = ~tx_byte[7];
                end
            end
            else if (state == sl_rdata && bitcnt != 4'd0)
                drive_low = ~tx_byte[7 - bitcnt]; // next bit while scl low
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defines.svh"

module tb_eeprom_ctrl;

    localparam int NUM_ENTRIES = 19;
    localparam int SCL_CYCLES  = 4 * `EE_SCL_QUARTER;
    localparam int MEM_SIZE    = 1 << `EE_ADDR_W;

    typedef struct packed
    {
        logic                 rd;
        eeprom_pkg::ee_addr_t addr;
        eeprom_pkg::ee_data_t data;
        logic                 present;
        logic                 extra;    // second strobe while busy
        eeprom_pkg::ee_data_t exp_rd;
        logic                 exp_nack;
    } entry_t;

    logic                 CLK;
    logic                 RESET;
    logic                 wr;
    logic                 rd;
    eeprom_pkg::ee_addr_t addr;
    eeprom_pkg::ee_data_t wr_data;
    eeprom_pkg::ee_data_t rd_data;
    logic                 ack;
    logic                 nack;
    logic                 busy;
    logic                 scl;
    wire                  sda;
    logic                 present;

    entry_t               entries [NUM_ENTRIES];
    string                names [NUM_ENTRIES];
    eeprom_pkg::ee_data_t ref_mem [MEM_SIZE];
    integer               seed;
    int                   errors;
    int                   ack_count;
    int                   n_entries;

    pullup (sda);

    eeprom_ctrl_top dut0
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .nack    (nack),
        .busy    (busy),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_slave_model slave0
    (
        .scl     (scl),
        .sda     (sda),
        .present (present)
    );

    always #5 CLK = ~CLK;

    always @(negedge CLK)
    begin
        if (ack === 1'b1)
            ack_count++;
    end

    // contents of a never written location
    function automatic eeprom_pkg::ee_data_t blank_byte(input eeprom_pkg::ee_addr_t a);
        blank_byte = a[7:0] ^ 8'h5a;
    endfunction

    task automatic add_entry(input string name, input logic is_rd,
                             input eeprom_pkg::ee_addr_t a, input eeprom_pkg::ee_data_t d,
                             input logic pres, input logic extra,
                             input eeprom_pkg::ee_data_t exp_rd, input logic exp_nack);
        entry_t e;
        e.rd       = is_rd;
        e.addr     = a;
        e.data     = d;
        e.present  = pres;
        e.extra    = extra;
        e.exp_rd   = exp_rd;
        e.exp_nack = exp_nack;
        names[n_entries]   = name;
        entries[n_entries] = e;
        n_entries++;
    endtask

    // rd_data has to hold the last read value across writes and failed reads
    task automatic build_table;
        eeprom_pkg::ee_data_t d [6];
        int i;
        for (i = 0; i < 6; i++)
            d[i] = 8'($random(seed));
        add_entry("read_blank_100", 1, 11'h100, 8'h00, 1, 0, blank_byte(11'h100), 0);
        add_entry("write_0a5", 0, 11'h0a5, d[0], 1, 0, blank_byte(11'h100), 0);
        add_entry("read_0a5", 1, 11'h0a5, 8'h00, 1, 0, d[0], 0);
        add_entry("read_blank_7ff", 1, 11'h7ff, 8'h00, 1, 0, blank_byte(11'h7ff), 0);
        add_entry("write_033", 0, 11'h033, d[1], 1, 0, blank_byte(11'h7ff), 0);
        add_entry("write_533", 0, 11'h533, d[2], 1, 0, blank_byte(11'h7ff), 0);
        add_entry("write_733", 0, 11'h733, d[3], 1, 0, blank_byte(11'h7ff), 0);
        add_entry("read_033", 1, 11'h033, 8'h00, 1, 0, d[1], 0);
        add_entry("read_533", 1, 11'h533, 8'h00, 1, 0, d[2], 0);
        add_entry("read_733", 1, 11'h733, 8'h00, 1, 0, d[3], 0);
        add_entry("read_blank_333", 1, 11'h333, 8'h00, 1, 0, blank_byte(11'h333), 0);
        add_entry("absent_write_0a5", 0, 11'h0a5, d[4], 0, 0, blank_byte(11'h333), 1);
        add_entry("absent_read_0a5", 1, 11'h0a5, 8'h00, 0, 0, blank_byte(11'h333), 1);
        add_entry("read_0a5_again", 1, 11'h0a5, 8'h00, 1, 0, d[0], 0);
        add_entry("busy_write_2c4", 0, 11'h2c4, d[5], 1, 1, d[0], 0);
        add_entry("read_2c4", 1, 11'h2c4, 8'h00, 1, 0, d[5], 0);
        add_entry("busy_read_533", 1, 11'h533, 8'h00, 1, 1, d[2], 0);
        add_entry("read_blank_6c4", 1, 11'h6c4, 8'h00, 1, 0, blank_byte(11'h6c4), 0);
        add_entry("read_blank_133", 1, 11'h133, 8'h00, 1, 0, blank_byte(11'h133), 0);
    endtask

    task automatic init_reference;
        int i;
        for (i = 0; i < MEM_SIZE; i++)
            ref_mem[i] = blank_byte(eeprom_pkg::ee_addr_t'(i));
    endtask

    task automatic check_idle;
        if (scl !== 1'b1 || sda !== 1'b1)
        begin
            $display("FAILED idle_after_reset: scl/sda expected 1/1 got %b/%b", scl, sda);
            errors++;
        end
        if (busy !== 1'b0 || ack !== 1'b0 || nack !== 1'b0)
        begin
            $display("FAILED idle_after_reset: busy/ack/nack expected 000 got %b%b%b",
                     busy, ack, nack);
            errors++;
        end
    endtask

    task automatic run_entry(input int k);
        entry_t e;
        int     acks_before;
        e = entries[k];
        acks_before = ack_count;
        @(posedge CLK);
        #1;
        present = e.present;
        wr      = !e.rd;
        rd      = e.rd;
        addr    = e.addr;
        wr_data = e.data;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        @(negedge CLK);
        if (busy !== 1'b1)
        begin
            $display("FAILED %s: busy expected 1 got %b", names[k], busy);
            errors++;
        end
        if (e.extra)
        begin
            @(posedge CLK);
            #1;
            wr      = 1'b1;           // other block, inverted data
            addr    = e.addr ^ 11'h400;
            wr_data = ~e.data;
            @(posedge CLK);
            #1;
            wr = 1'b0;
            rd = 1'b1;
            @(posedge CLK);
            #1;
            rd = 1'b0;
        end
        while (ack !== 1'b1)
            @(negedge CLK);
        if (busy !== 1'b0)
        begin
            $display("FAILED %s: busy at ack expected 0 got %b", names[k], busy);
            errors++;
        end
        if (nack !== e.exp_nack)
        begin
            $display("FAILED %s: nack expected %b got %b", names[k], e.exp_nack, nack);
            errors++;
        end
        if (rd_data !== e.exp_rd)
        begin
            $display("FAILED %s: rd_data expected %h got %h", names[k], e.exp_rd, rd_data);
            errors++;
        end
        if (!e.rd && e.present)
            ref_mem[e.addr] = e.data;
        repeat (2 * SCL_CYCLES) @(negedge CLK);
        if (ack_count - acks_before != 1 || busy !== 1'b0)
        begin
            $display("FAILED %s: ack count expected 1 got %0d, busy %b", names[k],
                     ack_count - acks_before, busy);
            errors++;
        end
    endtask

    task automatic compare_memory;
        int i;
        for (i = 0; i < MEM_SIZE; i++)
        begin
            if (slave0.mem[i] !== ref_mem[i])
            begin
                $display("FAILED memory_sweep: byte %h expected %h got %h", i[10:0],
                         ref_mem[i], slave0.mem[i]);
                errors++;
            end
        end
    endtask

    initial
    begin
        CLK       = 1'b0;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        present   = 1'b1;
        seed      = 32'he1f4f0bb;
        errors    = 0;
        ack_count = 0;
        n_entries = 0;
        init_reference();
        build_table();
        repeat (5) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(negedge CLK);
        check_idle();
        for (int k = 0; k < n_entries; k++)
            run_entry(k);
        compare_memory();
        $display("%0d entries, %0d acks, %0d errors", n_entries, ack_count, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // 50 scl periods per entry is well above a random read
    initial
    begin
        #(NUM_ENTRIES * 50 * SCL_CYCLES * 10);
        $display("timeout: the controller did not finish all requests in time, %0d errors",
                 errors);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/i2c_bus_pkg.sv
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_req_regs.sv
design/eeprom_ctrl_top.sv
bench/eeprom_slave_model.sv
bench/tb_eeprom_ctrl.sv
